/* src.f */
+incdir+hdl
hdl/lvds_pkg.sv
hdl/lvds_frame_if.sv
hdl/sample_ram.sv
hdl/buf_arbiter.sv
hdl/tx_playback.sv
hdl/rx_capture.sv
hdl/apb_ctrl.sv
hdl/lvds_subsys_top.sv
testbench/tb_lvds_subsys.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := tb_lvds_subsys
FILELIST := src.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* testbench/tb_lvds_subsys.sv */
// directed testbench for the AD9361 data port subsystem
// pins carry one step word per d_clk with both DDR halves combined
// tx frames are rebuilt from tx_frame and tx_word at the falling edge
// every wait is bounded by its own cycle limit

`timescale 1ns/1ps

`include "lvds_settings.svh"

module tb_lvds_subsys;

  localparam int W  = `LVDS_SAMPLE_W;
  localparam int H  = `LVDS_SAMPLE_W / 2;
  localparam int AW = `LVDS_APB_AW;

  localparam logic [AW-1:0] ADDR_CTRL   = 'h000;
  localparam logic [AW-1:0] ADDR_LEN    = 'h004;
  localparam logic [AW-1:0] ADDR_STATUS = 'h008;

  localparam int APB_TIMEOUT   = 16;
  localparam int FRAME_TIMEOUT = 64;
  localparam int STATUS_POLLS  = 32;

  logic          d_clk;
  logic          lock;
  logic          psel;
  logic          penable;
  logic          pwrite;
  logic [AW-1:0] paddr;
  logic [31:0]   pwdata;
  logic [31:0]   prdata;
  logic          pready;
  logic          pslverr;
  logic          tx_frame;
  logic [W-1:0]  tx_word;
  logic          rx_frame;
  logic [W-1:0]  rx_word;

  integer seed = 32'h847;
  int     errors = 0;
  int     checks = 0;
  int     timeouts = 0;
  string  test_name = "init";
  int     play_k = 0;

  // tx frame decoder state, frames are {i0, q0, i1, q1}
  logic [4*W-1:0] tx_frames [$];
  bit             dec_on = 1'b0;
  bit             dec_sync = 1'b0;
  logic [1:0]     dec_step = 2'd0;
  logic           dec_frame_q = 1'b0;
  logic [W-1:0]   dec_w [4];

  logic [31:0]    win_words [`LVDS_BUF_DEPTH];
  logic [31:0]    pb_words [6];
  logic [W-1:0]   cap_smp [16];

  lvds_subsys_top i_dut (
    .d_clk    (d_clk),
    .lock     (lock),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .tx_frame (tx_frame),
    .tx_word  (tx_word),
    .rx_frame (rx_frame),
    .rx_word  (rx_word)
  );

  initial begin
    d_clk = 1'b0;
    forever #20 d_clk = ~d_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // tx pin decoder, a rising tx_frame marks step 0
  always @(negedge d_clk) begin
    if (tx_frame === 1'b1 && dec_frame_q === 1'b0) begin
      dec_sync = 1'b1;
      dec_step = 2'd0;
    end
    if (dec_sync) begin
      dec_w[dec_step] = tx_word;
      if (dec_step == 2'd3) begin
        dec_sync = 1'b0;
        if (dec_on) begin
          tx_frames.push_back({dec_w[0][W-1:H], dec_w[1][W-1:H],
                               dec_w[0][H-1:0], dec_w[1][H-1:0],
                               dec_w[2][W-1:H], dec_w[3][W-1:H],
                               dec_w[2][H-1:0], dec_w[3][H-1:0]});
        end
      end
      dec_step = dec_step + 2'd1;
    end
    dec_frame_q = tx_frame;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
               test_name, what, expected, actual);
    end
  endtask

  function automatic logic [AW-1:0] word_addr(input int n);
    return AW'('h100 + 4 * n);
  endfunction

  // buffer words 2k and 2k+1 hold {i, q} of channel 0 and 1
  function automatic logic [4*W-1:0] expected_tx_frame(input int k);
    logic [31:0] w0;
    logic [31:0] w1;
    w0 = pb_words[2*k];
    w1 = pb_words[2*k+1];
    return {w0[2*W-1:W], w0[W-1:0], w1[2*W-1:W], w1[W-1:0]};
  endfunction

  task automatic apb_transfer(input logic wr, input logic [AW-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int waits;
    bit done;
    waits = 0;
    done  = 1'b0;
    rdata = '0;
    err   = 1'b0;
    @(posedge d_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge d_clk);
    penable <= 1'b1;
    while (!done && waits < APB_TIMEOUT) begin
      @(negedge d_clk);
      if (pready === 1'b1) begin
        done  = 1'b1;
        rdata = prdata;
        err   = pslverr;
      end else begin
        waits++;
      end
    end
    @(posedge d_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    if (!done) begin
      timeouts++;
      $display("timeout: %s got no pready at address 0x%03h within %0d cycles",
               test_name, addr, APB_TIMEOUT);
    end
  endtask

  task automatic apb_write(input logic [AW-1:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused_rd;
    apb_transfer(1'b1, addr, data, unused_rd, err);
  endtask

  task automatic apb_read(input logic [AW-1:0] addr, output logic [31:0] data,
                          output logic err);
    apb_transfer(1'b0, addr, 32'd0, data, err);
  endtask

  task automatic next_tx_frame(output logic [4*W-1:0] frame, output bit ok);
    int waits;
    waits = 0;
    frame = '0;
    while (tx_frames.size() == 0 && waits < FRAME_TIMEOUT) begin
      @(posedge d_clk);
      waits++;
    end
    ok = (tx_frames.size() != 0);
    if (ok) begin
      frame = tx_frames.pop_front();
    end else begin
      timeouts++;
      $display("timeout: %s saw no tx frame within %0d cycles", test_name, FRAME_TIMEOUT);
    end
  endtask

  // rx pin model, hi halves then lo halves, channel 0 first
  task automatic drive_rx_frame(input logic [W-1:0] i0, input logic [W-1:0] q0,
                                input logic [W-1:0] i1, input logic [W-1:0] q1);
    logic [4*W-1:0] seq;
    int             s;
    seq = {i0[W-1:H], q0[W-1:H], i0[H-1:0], q0[H-1:0],
           i1[W-1:H], q1[W-1:H], i1[H-1:0], q1[H-1:0]};
    for (s = 0; s < 4; s++) begin
      @(posedge d_clk);
      rx_frame <= (s < 2);
      rx_word  <= seq[4*W-1 -: W];
      seq = seq << W;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  task automatic reset_and_idle();
    int   n;
    logic exp_frame;
    test_name = "reset_idle";
    @(posedge d_clk);
    @(negedge d_clk);
    check_value("tx_frame with lock low", 64'(1'b0), 64'(tx_frame));
    check_value("tx_word with lock low", 64'(0), 64'(tx_word));
    @(posedge d_clk);
    lock <= 1'b1;
    // release takes LVDS_RST_STAGES edges after lock rises
    for (n = 0; n < `LVDS_RST_STAGES + 1; n++) begin
      @(negedge d_clk);
      check_value("tx_frame during release", 64'(1'b0), 64'(tx_frame));
      check_value("tx_word during release", 64'(0), 64'(tx_word));
    end
    for (n = 0; n < 8; n++) begin
      @(negedge d_clk);
      exp_frame = (n % 4) < 2;
      check_value($sformatf("tx_frame step %0d", n), 64'(exp_frame), 64'(tx_frame));
    end
  endtask

  task automatic register_access();
    logic [31:0] rd;
    logic        err;
    test_name = "registers";
    apb_write(ADDR_LEN, 32'd5, err);
    check_value("LEN write pslverr", 64'(1'b0), 64'(err));
    apb_read(ADDR_LEN, rd, err);
    check_value("LEN readback", 64'(5), 64'(rd));
    apb_write(ADDR_CTRL, 32'd2, err);
    apb_read(ADDR_CTRL, rd, err);
    check_value("CTRL readback", 64'(2), 64'(rd));
    check_value("CTRL read pslverr", 64'(1'b0), 64'(err));
    apb_write(ADDR_CTRL, 32'd0, err);
    apb_read(ADDR_STATUS, rd, err);
    check_value("STATUS idle", 64'(0), 64'(rd));
    apb_read(AW'('h00C), rd, err);
    check_value("unmapped read pslverr", 64'(1'b1), 64'(err));
    apb_write(AW'('h0F0), 32'hA5A5_A5A5, err);
    check_value("unmapped write pslverr", 64'(1'b1), 64'(err));
  endtask

  task automatic buffer_window_rw();
    logic [31:0] rd;
    logic        err;
    int          n;
    test_name = "buffer_window";
    for (n = 0; n < `LVDS_BUF_DEPTH; n++) begin
      win_words[n] = $random(seed);
      apb_write(word_addr(n), win_words[n], err);
    end
    for (n = 0; n < `LVDS_BUF_DEPTH; n++) begin
      apb_read(word_addr(n), rd, err);
      check_value($sformatf("word %0d", n), 64'(win_words[n]), 64'(rd));
      check_value($sformatf("word %0d pslverr", n), 64'(1'b0), 64'(err));
    end
  endtask

  task automatic playback_loop();
    logic           err;
    logic [4*W-1:0] f;
    bit             ok;
    int             n;
    int             skip;
    test_name = "playback";
    apb_write(ADDR_LEN, 32'd3, err);
    for (n = 0; n < 6; n++) begin
      pb_words[n] = $random(seed) & 32'h00FF_FFFF;
      apb_write(word_addr(n), pb_words[n], err);
    end
    tx_frames.delete();
    dec_on = 1'b1;
    apb_write(ADDR_CTRL, 32'd1, err);
    // zero frames go out until the first pair is loaded
    skip = 0;
    next_tx_frame(f, ok);
    while (ok && f == '0 && skip < 8) begin
      skip++;
      next_tx_frame(f, ok);
    end
    play_k = 0;
    for (n = 0; n < 6; n++) begin
      if (n > 0) begin
        next_tx_frame(f, ok);
      end
      if (ok) begin
        check_value($sformatf("frame %0d", play_k), 64'(expected_tx_frame(play_k % 3)),
                    64'(f));
      end
      play_k++;
    end
  endtask

  task automatic host_reads_in_playback();
    logic [31:0]    rd;
    logic           err;
    logic [4*W-1:0] f;
    bit             ok;
    int             r;
    int             pending;
    test_name = "host_during_playback";
    for (r = 0; r < 12; r++) begin
      apb_read(word_addr(r % 6), rd, err);
      check_value($sformatf("word %0d", r % 6), 64'(pb_words[r % 6]), 64'(rd));
    end
    pending = tx_frames.size();
    if (pending < 4) begin
      pending = 4;
    end
    // the loop must continue where the playback test left it
    for (r = 0; r < pending; r++) begin
      next_tx_frame(f, ok);
      if (ok) begin
        check_value($sformatf("frame %0d", play_k), 64'(expected_tx_frame(play_k % 3)),
                    64'(f));
      end
      play_k++;
    end
    apb_write(ADDR_CTRL, 32'd0, err);
    dec_on = 1'b0;
    tx_frames.delete();
  endtask

  task automatic capture_frames();
    logic [31:0] rd;
    logic        err;
    bit          done;
    int          n;
    int          polls;
    test_name = "capture";
    for (n = 0; n < 16; n++) begin
      cap_smp[n] = W'($random(seed));
    end
    apb_write(ADDR_LEN, 32'd4, err);
    apb_write(ADDR_CTRL, 32'd3, err);
    for (n = 0; n < 4; n++) begin
      drive_rx_frame(cap_smp[4*n], cap_smp[4*n+1], cap_smp[4*n+2], cap_smp[4*n+3]);
    end
    @(posedge d_clk);
    rx_word <= '0;
    done  = 1'b0;
    polls = 0;
    while (!done && polls < STATUS_POLLS) begin
      apb_read(ADDR_STATUS, rd, err);
      done = rd[0];
      polls++;
    end
    if (!done) begin
      timeouts++;
      $display("timeout: capture_done still clear after %0d STATUS reads", polls);
    end
    // only i and q are defined, upper bits are not compared
    for (n = 0; n < 8; n++) begin
      apb_read(word_addr(n), rd, err);
      check_value($sformatf("word %0d", n),
                  64'({cap_smp[2*n], cap_smp[2*n+1]}), 64'(rd[2*W-1:0]));
    end
    apb_write(ADDR_CTRL, 32'd0, err);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  initial begin
    lock     <= 1'b0;
    psel     <= 1'b0;
    penable  <= 1'b0;
    pwrite   <= 1'b0;
    paddr    <= '0;
    pwdata   <= '0;
    rx_frame <= 1'b0;
    rx_word  <= '0;

    reset_and_idle();
    register_access();
    buffer_window_rw();
    playback_loop();
    host_reads_in_playback();
    capture_frames();

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* hdl/lvds_subsys_top.sv */
// baseband side of a full duplex AD9361 port with a shared sample buffer
// d_clk and lock come from an external clock generator
// every enable write restarts the selected stream from frame 0

`timescale 1ns/1ps

`include "lvds_settings.svh"

module lvds_subsys_top import lvds_pkg::*; (
  input  logic                      d_clk,
  input  logic                      lock,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`LVDS_APB_AW-1:0]   paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      tx_frame,
  output logic [`LVDS_SAMPLE_W-1:0] tx_word,
  input  logic                      rx_frame,
  input  logic [`LVDS_SAMPLE_W-1:0] rx_word
);

  logic                      d_rst;
  logic [`LVDS_SAMPLE_W-1:0] tx_i0, tx_q0, tx_i1, tx_q1;
  logic [`LVDS_SAMPLE_W-1:0] rx_i0, rx_q0, rx_i1, rx_q1;
  logic                      tx_done, rx_done;
  logic                      rx_req, rx_we, rx_gnt;
  logic [`LVDS_BUF_AW-1:0]   rx_addr;
  buf_word_u                 rx_wdata;
  logic                      tx_req, tx_gnt, tx_rvalid;
  logic [`LVDS_BUF_AW-1:0]   tx_addr;
  logic                      host_req, host_we, host_gnt, host_rvalid;
  logic [`LVDS_BUF_AW-1:0]   host_addr;
  buf_word_u                 host_wdata;
  buf_word_u                 rd_data;
  logic                      play_run, cap_run, run_start;
  logic                      play_go, cap_go;
  logic [`LVDS_BUF_AW-1:0]   len;
  logic                      capture_done;

  // one idle cycle on each enable write resets the stream blocks
  assign play_go = play_run & ~run_start;
  assign cap_go  = cap_run & ~run_start;

  lvds_frame_if i_frame (
    .d_clk (d_clk), .lock (lock),
    .tx_i0 (tx_i0), .tx_q0 (tx_q0), .tx_i1 (tx_i1), .tx_q1 (tx_q1),
    .rx_frame (rx_frame), .rx_word (rx_word),
    .tx_frame (tx_frame), .tx_word (tx_word), .tx_done (tx_done),
    .rx_done (rx_done),
    .rx_i0 (rx_i0), .rx_q0 (rx_q0), .rx_i1 (rx_i1), .rx_q1 (rx_q1),
    .d_rst (d_rst)
  );

  // playback only reads, capture does not read back
  buf_arbiter i_arb (
    .d_clk (d_clk), .d_rst (d_rst),
    .rx_req (rx_req), .rx_we (rx_we), .rx_addr (rx_addr), .rx_wdata (rx_wdata),
    .tx_req (tx_req), .tx_we (1'b0), .tx_addr (tx_addr), .tx_wdata ('0),
    .host_req (host_req), .host_we (host_we), .host_addr (host_addr),
    .host_wdata (host_wdata),
    .rx_gnt (rx_gnt), .tx_gnt (tx_gnt), .host_gnt (host_gnt),
    .rx_rvalid (), .tx_rvalid (tx_rvalid), .host_rvalid (host_rvalid),
    .rd_data (rd_data)
  );

  tx_playback i_play (
    .d_clk (d_clk), .d_rst (d_rst), .run (play_go), .len (len),
    .tx_done (tx_done), .tx_gnt (tx_gnt), .tx_rvalid (tx_rvalid),
    .rd_data (rd_data), .tx_req (tx_req), .tx_addr (tx_addr),
    .tx_i0 (tx_i0), .tx_q0 (tx_q0), .tx_i1 (tx_i1), .tx_q1 (tx_q1)
  );

  rx_capture i_cap (
    .d_clk (d_clk), .d_rst (d_rst), .run (cap_go), .len (len),
    .rx_done (rx_done),
    .rx_i0 (rx_i0), .rx_q0 (rx_q0), .rx_i1 (rx_i1), .rx_q1 (rx_q1),
    .rx_gnt (rx_gnt), .rx_req (rx_req), .rx_we (rx_we), .rx_addr (rx_addr),
    .rx_wdata (rx_wdata), .capture_done (capture_done)
  );

  apb_ctrl i_apb (
    .d_clk (d_clk), .d_rst (d_rst),
    .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
    .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
    .host_req (host_req), .host_we (host_we), .host_addr (host_addr),
    .host_wdata (host_wdata), .host_gnt (host_gnt),
    .host_rvalid (host_rvalid), .rd_data (rd_data),
    .play_run (play_run), .cap_run (cap_run), .len (len),
    .capture_done (capture_done), .run_start (run_start)
  );

endmodule

/* hdl/apb_ctrl.sv */
// APB3 slave: CTRL, LEN, STATUS and a 64 word buffer window at 0x100
// register access has no wait states, buffer access waits on the arbiter
// unmapped addresses complete with pslverr, STATUS ignores writes

`timescale 1ns/1ps

`include "lvds_settings.svh"

module apb_ctrl import lvds_pkg::*; (
  input  logic                    d_clk,
  input  logic                    d_rst,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`LVDS_APB_AW-1:0] paddr,
  input  logic [31:0]             pwdata,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic                    host_req,
  output logic                    host_we,
  output logic [`LVDS_BUF_AW-1:0] host_addr,
  output buf_word_u               host_wdata,
  input  logic                    host_gnt,
  input  logic                    host_rvalid,
  input  buf_word_u               rd_data,
  output logic                    play_run,
  output logic                    cap_run,
  output logic [`LVDS_BUF_AW-1:0] len,
  input  logic                    capture_done,
  output logic                    run_start
);

  localparam logic [`LVDS_APB_AW-1:0] ADDR_CTRL   = 'h000;
  localparam logic [`LVDS_APB_AW-1:0] ADDR_LEN    = 'h004;
  localparam logic [`LVDS_APB_AW-1:0] ADDR_STATUS = 'h008;

  logic      access;
  logic      win_hit;
  logic      reg_hit;
  logic      rd_pend;
  logic      enable;
  logic      busy;
  buf_mode_e mode;

  ////////////////////////////////////////////////////////////////////////////
  // decode
  assign access  = psel & penable;
  assign win_hit = (paddr[`LVDS_APB_AW-1:8] == 'h1) & (paddr[1:0] == 2'b00);
  assign reg_hit = (paddr == ADDR_CTRL) | (paddr == ADDR_LEN) | (paddr == ADDR_STATUS);

  // buffer window becomes one arbiter request per transfer
  assign host_req        = access & win_hit & ~rd_pend;
  assign host_we         = pwrite;
  assign host_addr       = paddr[`LVDS_BUF_AW+1:2];
  assign host_wdata.raw  = pwdata;

  // writes finish on grant, reads when the data returns
  assign pready  = access & (~win_hit | (pwrite ? host_gnt : host_rvalid));
  assign pslverr = pready & ~win_hit & ~reg_hit;

  assign play_run = enable & (mode == mode_playback);
  assign cap_run  = enable & (mode == mode_capture);
  assign busy     = play_run | (cap_run & ~capture_done);

  always_comb begin
    prdata = '0;
    if (win_hit) begin
      prdata = rd_data.raw;
    end else if (paddr == ADDR_CTRL) begin
      prdata[1:0] = {mode, enable};
    end else if (paddr == ADDR_LEN) begin
      prdata[`LVDS_BUF_AW-1:0] = len;
    end else if (paddr == ADDR_STATUS) begin
      prdata[1:0] = {busy, capture_done};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // control registers
  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      enable    <= 1'b0;
      mode      <= mode_playback;
      len       <= 'd1;
      run_start <= 1'b0;
      rd_pend   <= 1'b0;
    end else begin
      run_start <= 1'b0;
      if (host_gnt && !pwrite) begin
        rd_pend <= 1'b1;
      end else if (host_rvalid) begin
        rd_pend <= 1'b0;
      end
      if (access && pwrite && paddr == ADDR_CTRL) begin
        enable    <= pwdata[0];
        mode      <= buf_mode_e'(pwdata[1]);
        run_start <= pwdata[0];
      end
      if (access && pwrite && paddr == ADDR_LEN) begin
        len <= pwdata[`LVDS_BUF_AW-1:0];
      end
    end
  end

  a_pready_in_access: assert property (@(posedge d_clk) disable iff (d_rst)
    pready |-> psel && penable);

endmodule

/* hdl/rx_capture.sv */
// stores len received frames from the first rx_done after run
// frame k lands in words 2k and 2k+1, then capture_done holds
// run low clears the count and capture_done

`timescale 1ns/1ps

`include "lvds_settings.svh"

module rx_capture import lvds_pkg::*; (
  input  logic                      d_clk,
  input  logic                      d_rst,
  input  logic                      run,
  input  logic [`LVDS_BUF_AW-1:0]   len,
  input  logic                      rx_done,
  input  logic [`LVDS_SAMPLE_W-1:0] rx_i0,
  input  logic [`LVDS_SAMPLE_W-1:0] rx_q0,
  input  logic [`LVDS_SAMPLE_W-1:0] rx_i1,
  input  logic [`LVDS_SAMPLE_W-1:0] rx_q1,
  input  logic                      rx_gnt,
  output logic                      rx_req,
  output logic                      rx_we,
  output logic [`LVDS_BUF_AW-1:0]   rx_addr,
  output buf_word_u                 rx_wdata,
  output logic                      capture_done
);

  logic [`LVDS_BUF_AW-2:0] fcnt;
  logic                    pend;
  logic                    wsel;
  logic                    take;
  buf_word_u               lat0;
  buf_word_u               lat1;

  assign take     = run & rx_done & ~pend & ~capture_done;
  assign rx_req   = pend;
  assign rx_we    = pend;
  assign rx_addr  = {fcnt, wsel};
  assign rx_wdata = wsel ? lat1 : lat0;

  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      fcnt         <= '0;
      pend         <= 1'b0;
      wsel         <= 1'b0;
      capture_done <= 1'b0;
    end else if (!run) begin
      fcnt         <= '0;
      pend         <= 1'b0;
      wsel         <= 1'b0;
      capture_done <= 1'b0;
    end else begin
      if (take) begin
        pend <= 1'b1;
      end
      if (rx_gnt) begin
        wsel <= ~wsel;
        // second word written closes the frame
        if (wsel) begin
          pend <= 1'b0;
          fcnt <= fcnt + 1'b1;
          if ({1'b0, fcnt} + 1'b1 >= len) begin
            capture_done <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge d_clk) begin
    if (take) begin
      lat0.iq <= '{rsvd: '0, i: rx_i0, q: rx_q0};
      lat1.iq <= '{rsvd: '0, i: rx_i1, q: rx_q1};
    end
  end

endmodule

/* hdl/tx_playback.sv */
// loops buffer frames 0 to len-1 out to the transmitter
// outputs hold zero until the first frame is fetched
// dropping run restarts the loop from frame 0

`timescale 1ns/1ps

`include "lvds_settings.svh"

module tx_playback import lvds_pkg::*; (
  input  logic                      d_clk,
  input  logic                      d_rst,
  input  logic                      run,
  input  logic [`LVDS_BUF_AW-1:0]   len,
  input  logic                      tx_done,
  input  logic                      tx_gnt,
  input  logic                      tx_rvalid,
  input  buf_word_u                 rd_data,
  output logic                      tx_req,
  output logic [`LVDS_BUF_AW-1:0]   tx_addr,
  output logic [`LVDS_SAMPLE_W-1:0] tx_i0,
  output logic [`LVDS_SAMPLE_W-1:0] tx_q0,
  output logic [`LVDS_SAMPLE_W-1:0] tx_i1,
  output logic [`LVDS_SAMPLE_W-1:0] tx_q1
);

  logic [`LVDS_BUF_AW-2:0] idx;
  logic [`LVDS_BUF_AW-2:0] idx_nxt;
  logic [1:0]              req_cnt;
  logic                    rv_half;
  logic                    staged;
  iq_sample_t              stg0;
  iq_sample_t              stg1;

  // two reads per frame, channel 0 word first
  assign tx_req  = run & ~staged & (req_cnt != 2'd2);
  assign tx_addr = {idx, req_cnt[0]};
  assign idx_nxt = ({1'b0, idx} + 1'b1 >= len) ? '0 : idx + 1'b1;

  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      idx     <= '0;
      req_cnt <= 2'd0;
      rv_half <= 1'b0;
      staged  <= 1'b0;
      tx_i0   <= '0;
      tx_q0   <= '0;
      tx_i1   <= '0;
      tx_q1   <= '0;
    end else if (!run) begin
      idx     <= '0;
      req_cnt <= 2'd0;
      rv_half <= 1'b0;
      staged  <= 1'b0;
      tx_i0   <= '0;
      tx_q0   <= '0;
      tx_i1   <= '0;
      tx_q1   <= '0;
    end else begin
      if (tx_gnt) begin
        req_cnt <= req_cnt + 2'd1;
      end
      if (tx_rvalid) begin
        rv_half <= ~rv_half;
        staged  <= rv_half;
      end
      // hand over at the frame boundary
      if (tx_done && staged) begin
        tx_i0   <= stg0.i;
        tx_q0   <= stg0.q;
        tx_i1   <= stg1.i;
        tx_q1   <= stg1.q;
        idx     <= idx_nxt;
        req_cnt <= 2'd0;
        staged  <= 1'b0;
      end
    end
  end

  always_ff @(posedge d_clk) begin
    if (tx_rvalid) begin
      if (rv_half) begin
        stg1 <= rd_data.iq;
      end else begin
        stg0 <= rd_data.iq;
      end
    end
  end

endmodule

/* hdl/buf_arbiter.sv */
// fixed priority access to the sample buffer: rx, then tx, then host
// grants are combinational, read data returns one cycle after grant
// rx and tx never request together since one mode owns the buffer

`timescale 1ns/1ps

`include "lvds_settings.svh"

module buf_arbiter import lvds_pkg::*; (
  input  logic                    d_clk,
  input  logic                    d_rst,
  input  logic                    rx_req,
  input  logic                    rx_we,
  input  logic [`LVDS_BUF_AW-1:0] rx_addr,
  input  buf_word_u               rx_wdata,
  input  logic                    tx_req,
  input  logic                    tx_we,
  input  logic [`LVDS_BUF_AW-1:0] tx_addr,
  input  buf_word_u               tx_wdata,
  input  logic                    host_req,
  input  logic                    host_we,
  input  logic [`LVDS_BUF_AW-1:0] host_addr,
  input  buf_word_u               host_wdata,
  output logic                    rx_gnt,
  output logic                    tx_gnt,
  output logic                    host_gnt,
  output logic                    rx_rvalid,
  output logic                    tx_rvalid,
  output logic                    host_rvalid,
  output buf_word_u               rd_data
);

  logic                    ram_en;
  logic                    ram_we;
  logic [`LVDS_BUF_AW-1:0] ram_addr;
  buf_word_u               ram_wdata;

  assign rx_gnt   = rx_req;
  assign tx_gnt   = tx_req & ~rx_req;
  assign host_gnt = host_req & ~rx_req & ~tx_req;

  // steer the winner onto the RAM port
  always_comb begin
    ram_en = rx_req | tx_req | host_req;
    if (rx_req) begin
      ram_we    = rx_we;
      ram_addr  = rx_addr;
      ram_wdata = rx_wdata;
    end else if (tx_req) begin
      ram_we    = tx_we;
      ram_addr  = tx_addr;
      ram_wdata = tx_wdata;
    end else begin
      ram_we    = host_we;
      ram_addr  = host_addr;
      ram_wdata = host_wdata;
    end
  end

  // remember who read so the data goes back to them
  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      rx_rvalid   <= 1'b0;
      tx_rvalid   <= 1'b0;
      host_rvalid <= 1'b0;
    end else begin
      rx_rvalid   <= rx_gnt & ~rx_we;
      tx_rvalid   <= tx_gnt & ~tx_we;
      host_rvalid <= host_gnt & ~host_we;
    end
  end

  sample_ram #(
    .DEPTH (`LVDS_BUF_DEPTH)
  ) i_ram (
    .d_clk (d_clk),
    .en    (ram_en),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (rd_data)
  );

  a_one_stream: assert property (@(posedge d_clk) disable iff (d_rst)
    !(rx_req && tx_req));

endmodule

/* hdl/sample_ram.sv */
// single port sample buffer, read data valid one cycle after en
// contents are undefined after power up

`timescale 1ns/1ps

`include "lvds_settings.svh"

module sample_ram import lvds_pkg::*; #(
  parameter int DEPTH = `LVDS_BUF_DEPTH
) (
  input  logic                     d_clk,
  input  logic                     en,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  buf_word_u                wdata,
  output buf_word_u                rdata
);

  buf_word_u mem [DEPTH];

  always_ff @(posedge d_clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];
    end
  end

endmodule

/* hdl/lvds_frame_if.sv */
// frame level data port for one AD9361, two channels per frame
// each step word arrives with both DDR halves already combined
// rx framing needs a rising edge of rx_frame before rx_done can pulse

`timescale 1ns/1ps

`include "lvds_settings.svh"

module lvds_frame_if (
  input  logic                       d_clk,
  input  logic                       lock,
  input  logic [`LVDS_SAMPLE_W-1:0]  tx_i0,
  input  logic [`LVDS_SAMPLE_W-1:0]  tx_q0,
  input  logic [`LVDS_SAMPLE_W-1:0]  tx_i1,
  input  logic [`LVDS_SAMPLE_W-1:0]  tx_q1,
  input  logic                       rx_frame,
  input  logic [`LVDS_SAMPLE_W-1:0]  rx_word,
  output logic                       tx_frame,
  output logic [`LVDS_SAMPLE_W-1:0]  tx_word,
  output logic                       tx_done,
  output logic                       rx_done,
  output logic [`LVDS_SAMPLE_W-1:0]  rx_i0,
  output logic [`LVDS_SAMPLE_W-1:0]  rx_q0,
  output logic [`LVDS_SAMPLE_W-1:0]  rx_i1,
  output logic [`LVDS_SAMPLE_W-1:0]  rx_q1,
  output logic                       d_rst
);

  localparam int W = `LVDS_SAMPLE_W;
  localparam int H = `LVDS_SAMPLE_W / 2;

  logic [`LVDS_RST_STAGES-1:0] rst_sh;
  logic [1:0]   tx_step;
  logic [W-1:0] tx_slice;
  logic [1:0]   rx_step;
  logic [1:0]   rx_cur;
  logic         rx_frame_q;
  logic         rx_rise;
  logic         rx_sync;
  logic [W-1:0] stg_i0;
  logic [W-1:0] stg_q0;
  logic [H-1:0] stg_i1_hi;
  logic [H-1:0] stg_q1_hi;

  ////////////////////////////////////////////////////////////////////////////
  // internal reset, set at once by lock low, drained by d_clk
  always_ff @(posedge d_clk or negedge lock) begin
    if (!lock) begin
      rst_sh <= '1;
    end else begin
      rst_sh <= {1'b0, rst_sh[`LVDS_RST_STAGES-1:1]};
    end
  end

  assign d_rst = rst_sh[0];

  ////////////////////////////////////////////////////////////////////////////
  // transmit: i hi/q hi then i lo/q lo, channel 0 first
  always_comb begin
    case (tx_step)
      2'd0:    tx_slice = {tx_i0[W-1:H], tx_q0[W-1:H]};
      2'd1:    tx_slice = {tx_i0[H-1:0], tx_q0[H-1:0]};
      2'd2:    tx_slice = {tx_i1[W-1:H], tx_q1[W-1:H]};
      default: tx_slice = {tx_i1[H-1:0], tx_q1[H-1:0]};
    endcase
  end

  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      tx_step  <= 2'd0;
      tx_frame <= 1'b0;
      tx_word  <= '0;
    end else begin
      tx_step  <= tx_step + 2'd1;
      tx_frame <= ~tx_step[1];
      tx_word  <= tx_slice;
    end
  end

  // inputs sampled here feed the next frame
  assign tx_done = &tx_step;

  ////////////////////////////////////////////////////////////////////////////
  // receive: rising rx_frame restarts the step count
  assign rx_rise = rx_frame & ~rx_frame_q;
  assign rx_cur  = rx_rise ? 2'd0 : rx_step;

  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      rx_frame_q <= 1'b0;
      rx_step    <= 2'd0;
      rx_sync    <= 1'b0;
      rx_done    <= 1'b0;
    end else begin
      rx_frame_q <= rx_frame;
      rx_step    <= rx_cur + 2'd1;
      if (rx_rise) begin
        rx_sync <= 1'b1;
      end
      rx_done <= rx_sync & (rx_cur == 2'd3);
    end
  end

  // staging keeps the outputs steady between rx_done pulses
  always_ff @(posedge d_clk) begin
    case (rx_cur)
      2'd0: begin
        stg_i0[W-1:H] <= rx_word[W-1:H];
        stg_q0[W-1:H] <= rx_word[H-1:0];
      end
      2'd1: begin
        stg_i0[H-1:0] <= rx_word[W-1:H];
        stg_q0[H-1:0] <= rx_word[H-1:0];
      end
      2'd2: begin
        stg_i1_hi <= rx_word[W-1:H];
        stg_q1_hi <= rx_word[H-1:0];
      end
      default: begin
        if (rx_sync) begin
          rx_i0 <= stg_i0;
          rx_q0 <= stg_q0;
          rx_i1 <= {stg_i1_hi, rx_word[W-1:H]};
          rx_q1 <= {stg_q1_hi, rx_word[H-1:0]};
        end
      end
    endcase
  end

  a_rx_done_single: assert property (@(posedge d_clk) disable iff (d_rst)
    rx_done |=> !rx_done);

endmodule

/* hdl/lvds_pkg.sv */
// types shared by the buffer peers
// a buffer word holds one channel of one frame, i and q packed low

`include "lvds_settings.svh"

package lvds_pkg;

  // one channel sample pair as stored in a buffer word
  typedef struct packed {
    logic [31-2*`LVDS_SAMPLE_W:0] rsvd;
    logic [`LVDS_SAMPLE_W-1:0]    i;
    logic [`LVDS_SAMPLE_W-1:0]    q;
  } iq_sample_t;

  // host and RAM see raw words, streaming blocks see samples
  typedef union packed {
    logic [31:0] raw;
    iq_sample_t  iq;
  } buf_word_u;

  // which streaming direction owns the buffer
  typedef enum logic {
    mode_playback = 1'b0,
    mode_capture  = 1'b1
  } buf_mode_e;

endpackage

/* hdl/lvds_settings.svh */
// shared widths and sizes for the AD9361 data port subsystem
// buffer depth must stay a power of two and match LVDS_BUF_AW
// APB window at 0x100 assumes 64 words of 4 bytes

`ifndef LVDS_SETTINGS_SVH
`define LVDS_SETTINGS_SVH

// one I or Q sample, sent as two half words per step
`define LVDS_SAMPLE_W 12

// sample buffer
`define LVDS_BUF_DEPTH 64
`define LVDS_BUF_AW 6

// host bus
`define LVDS_APB_AW 12

// d_clk edges from lock rising to internal reset release
`define LVDS_RST_STAGES 3

`endif
